// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = alu_cluster_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: simulate clean

# the run passes only if the pass line shows up in the simulation output.
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/alu_cluster.sv
/*
  Two-lane ALU cluster. Lane 1 alone has the shifter, so shift opcodes must not
  be issued to lane 0. There is no back-pressure; issue may occur every cycle.
*/
`timescale 1ns/100ps

module alu_cluster (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    issue_valid_0,
  input  alu_ops_pkg::alu_op_t    op_0,
  input  alu_types_pkg::fwd_sel_t fwd_a_0,
  input  alu_types_pkg::fwd_sel_t fwd_b_0,
  input  alu_types_pkg::word_t    a_0,
  input  alu_types_pkg::word_t    b_0,
  output logic                    result_valid_0,
  output alu_types_pkg::word_t    result_0,
  output logic                    zero_0,
  input  logic                    issue_valid_1,
  input  alu_ops_pkg::alu_op_t    op_1,
  input  alu_types_pkg::fwd_sel_t fwd_a_1,
  input  alu_types_pkg::fwd_sel_t fwd_b_1,
  input  alu_types_pkg::word_t    a_1,
  input  alu_types_pkg::word_t    b_1,
  output logic                    result_valid_1,
  output alu_types_pkg::word_t    result_1,
  output logic                    zero_1
);
  import alu_types_pkg::*;

  result_bus_t result_bus;

  assign result_bus = {result_1, result_0}; // lane n at index n.

  alu_lane #(.has_shift(1'b0)) lane0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid_0),
    .op           (op_0),
    .fwd_a        (fwd_a_0),
    .fwd_b        (fwd_b_0),
    .a            (a_0),
    .b            (b_0),
    .results      (result_bus),
    .result_valid (result_valid_0),
    .result       (result_0),
    .zero         (zero_0)
  );

  alu_lane #(.has_shift(1'b1)) lane1 (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid_1),
    .op           (op_1),
    .fwd_a        (fwd_a_1),
    .fwd_b        (fwd_b_1),
    .a            (a_1),
    .b            (b_1),
    .results      (result_bus),
    .result_valid (result_valid_1),
    .result       (result_1),
    .zero         (zero_1)
  );

endmodule

// File: design/alu_lane.sv
/*
  One ALU lane with a fixed latency of 2 cycles. Shift opcodes are only legal
  when has_shift is set; otherwise they produce a zero result.
*/
`timescale 1ns/100ps

module alu_lane #(
  parameter bit has_shift = 1'b0
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       issue_valid,
  input  alu_ops_pkg::alu_op_t       op,
  input  alu_types_pkg::fwd_sel_t    fwd_a,
  input  alu_types_pkg::fwd_sel_t    fwd_b,
  input  alu_types_pkg::word_t       a,
  input  alu_types_pkg::word_t       b,
  input  alu_types_pkg::result_bus_t results,
  output logic                       result_valid,
  output alu_types_pkg::word_t       result,
  output logic                       zero
);
  import alu_types_pkg::*;
  import alu_ops_pkg::*;

  lane_ctrl_if ctrl ();

  word_t op_a;
  word_t op_b;
  word_t sum;
  word_t arith_res;
  word_t logic_res;
  word_t shift_res;
  word_t exec_res;

  op_decode u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .op          (op),
    .ctrl        (ctrl.producer)
  );

  operand_bypass u_bypass_a (
    .clk     (clk),
    .arst_n  (arst_n),
    .capture (issue_valid),
    .operand (a),
    .fwd     (fwd_a),
    .results (results),
    .value   (op_a)
  );

  operand_bypass u_bypass_b (
    .clk     (clk),
    .arst_n  (arst_n),
    .capture (issue_valid),
    .operand (b),
    .fwd     (fwd_b),
    .results (results),
    .value   (op_b)
  );

  assign sum       = ctrl.is_sub ? op_a - op_b : op_a + op_b;
  assign arith_res = ctrl.narrow ? {{(word_w-half_w){1'b0}}, sum[half_w-1:0]} : sum;

  always_comb begin
    case (ctrl.fn)
      fn_and:  logic_res = op_a & op_b;
      fn_or:   logic_res = op_a | op_b;
      fn_xor:  logic_res = op_a ^ op_b;
      default: logic_res = arith_res;
    endcase
  end

  generate
    if (has_shift) begin : g_shift
      shift_unit u_shift (
        .ctrl   (ctrl.consumer),
        .data   (op_a),
        .amount (shamt_t'(op_b[5:0])),
        .result (shift_res)
      );
    end else begin : g_no_shift
      assign shift_res = '0;
    end
  endgenerate

  assign exec_res = ctrl.is_shift ? shift_res : logic_res;

  // the result register holds the last result, which later bypass reads rely on.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
      zero         <= 1'b0;
    end else begin
      result_valid <= ctrl.valid;
      if (ctrl.valid) begin
        result <= exec_res;
        zero   <= (exec_res == '0);
      end
    end
  end

endmodule

// File: design/alu_ops_pkg.sv
/*
  Opcode encoding and the classification masks used by the decode stage.
  Codes 7, 14 and 15 are unused and decode as a 64-bit add.
*/
package alu_ops_pkg;

  typedef enum logic [3:0] {
    op_add64 = 4'd0,
    op_sub64 = 4'd1,
    op_add32 = 4'd2,
    op_sub32 = 4'd3,
    op_and   = 4'd4,
    op_or    = 4'd5,
    op_xor   = 4'd6,
    op_shl64 = 4'd8,
    op_shr64 = 4'd9,
    op_sar64 = 4'd10,
    op_shl32 = 4'd11,
    op_shr32 = 4'd12,
    op_sar32 = 4'd13
  } alu_op_t;

  typedef enum logic [1:0] {
    fn_arith = 2'd0,
    fn_and   = 2'd1,
    fn_or    = 2'd2,
    fn_xor   = 2'd3
  } logic_fn_t;

  // each mask has one bit per opcode value that is set for the opcodes in its class.
  localparam logic [15:0] sub_mask    = (16'd1 << op_sub64) | (16'd1 << op_sub32);
  localparam logic [15:0] shift_mask  = (16'd1 << op_shl64) | (16'd1 << op_shr64) |
                                        (16'd1 << op_sar64) | (16'd1 << op_shl32) |
                                        (16'd1 << op_shr32) | (16'd1 << op_sar32);
  localparam logic [15:0] right_mask  = (16'd1 << op_shr64) | (16'd1 << op_sar64) |
                                        (16'd1 << op_shr32) | (16'd1 << op_sar32);
  localparam logic [15:0] arith_mask  = (16'd1 << op_sar64) | (16'd1 << op_sar32);
  localparam logic [15:0] narrow_mask = (16'd1 << op_add32) | (16'd1 << op_sub32) |
                                        (16'd1 << op_shl32) | (16'd1 << op_shr32) |
                                        (16'd1 << op_sar32);

endpackage

// File: design/alu_types_pkg.sv
/*
  Data widths and bus types shared by both ALU lanes.
  The result bus has one word per lane, and lane n sits at index n.
*/
package alu_types_pkg;

  localparam int word_w     = 64;
  localparam int half_w     = 32;
  localparam int lane_count = 2;

  typedef logic [word_w-1:0] word_t;

  // shift amounts cover the full 64-bit range, and narrow forms use the low 5 bits.
  typedef logic [5:0] shamt_t;

  // value 3 of the operand source select is reserved and acts as the input.
  typedef logic [1:0] fwd_sel_t;

  localparam fwd_sel_t fwd_input = 2'd0;
  localparam fwd_sel_t fwd_lane0 = 2'd1;
  localparam fwd_sel_t fwd_lane1 = 2'd2;

  // all bypass units see every lane's result register on this bus.
  typedef logic [lane_count-1:0][word_w-1:0] result_bus_t;

endpackage

// File: design/lane_ctrl_if.sv
/*
  Decoded controls of one lane, valid during the execute cycle.
*/
`timescale 1ns/100ps

interface lane_ctrl_if;
  import alu_ops_pkg::*;

  logic      valid;
  logic      is_sub;
  logic_fn_t fn;
  logic      is_shift;
  logic      shift_right;
  logic      shift_arith;
  logic      narrow;

  modport producer (
    output valid, is_sub, fn, is_shift, shift_right, shift_arith, narrow
  );

  modport consumer (
    input valid, is_sub, fn, is_shift, shift_right, shift_arith, narrow
  );

endinterface

// File: design/op_decode.sv
/*
  Decode stage of one lane. Controls are registered on every edge, so they
  describe the operation issued on the previous edge, or none if valid is low.
*/
`timescale 1ns/100ps

module op_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 issue_valid,
  input  alu_ops_pkg::alu_op_t op,
  lane_ctrl_if.producer        ctrl
);
  import alu_ops_pkg::*;

  logic_fn_t fn_next;

  always_comb begin
    case (op)
      op_and:  fn_next = fn_and;
      op_or:   fn_next = fn_or;
      op_xor:  fn_next = fn_xor;
      default: fn_next = fn_arith; // adds, subs and shifts.
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl.valid       <= 1'b0;
      ctrl.is_sub      <= 1'b0;
      ctrl.fn          <= fn_arith;
      ctrl.is_shift    <= 1'b0;
      ctrl.shift_right <= 1'b0;
      ctrl.shift_arith <= 1'b0;
      ctrl.narrow      <= 1'b0;
    end else begin
      ctrl.valid       <= issue_valid;
      ctrl.is_sub      <= sub_mask[op];
      ctrl.fn          <= fn_next;
      ctrl.is_shift    <= shift_mask[op];
      ctrl.shift_right <= right_mask[op];
      ctrl.shift_arith <= arith_mask[op];
      ctrl.narrow      <= narrow_mask[op]; // 32-bit forms of add, sub and shifts.
    end
  end

endmodule

// File: design/operand_bypass.sv
/*
  One operand of one lane. The select picks from the live result bus in the
  execute cycle, so a consumer issued right after its producer sees the new result.
*/
`timescale 1ns/100ps

module operand_bypass (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      capture,
  input  alu_types_pkg::word_t      operand,
  input  alu_types_pkg::fwd_sel_t   fwd,
  input  alu_types_pkg::result_bus_t results,
  output alu_types_pkg::word_t      value
);
  import alu_types_pkg::*;

  word_t    operand_q;
  fwd_sel_t fwd_q;

  always_ff @(posedge clk) begin
    if (capture) operand_q <= operand;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fwd_q <= fwd_input;
    end else if (capture) begin
      fwd_q <= fwd;
    end
  end

  always_comb begin
    case (fwd_q)
      fwd_lane0: value = results[0];
      fwd_lane1: value = results[1];
      default:   value = operand_q; // the reserved code falls back to the input.
    endcase
  end

endmodule

// File: design/shift_unit.sv
/*
  Combinational barrel shifter. Narrow forms shift the low 32 bits by a 5-bit
  amount and return a zero-extended word; the upper bits of data are ignored.
*/
`timescale 1ns/100ps

module shift_unit (
  lane_ctrl_if.consumer          ctrl,
  input  alu_types_pkg::word_t   data,
  input  alu_types_pkg::shamt_t  amount,
  output alu_types_pkg::word_t   result
);
  import alu_types_pkg::*;

  word_t             wide_res;
  logic [half_w-1:0] half_in;
  logic [half_w-1:0] half_res;

  assign half_in = data[half_w-1:0];

  always_comb begin
    if (!ctrl.shift_right) begin
      wide_res = data << amount;
    end else if (ctrl.shift_arith) begin
      wide_res = word_t'($signed(data) >>> amount);
    end else begin
      wide_res = data >> amount;
    end
  end

  always_comb begin
    if (!ctrl.shift_right) begin
      half_res = half_in << amount[4:0];
    end else if (ctrl.shift_arith) begin
      half_res = $signed(half_in) >>> amount[4:0]; // sign comes from bit 31.
    end else begin
      half_res = half_in >> amount[4:0];
    end
  end

  assign result = ctrl.narrow ? {{(word_w-half_w){1'b0}}, half_res} : wide_res;

endmodule

// File: filelist.f
design/alu_types_pkg.sv
design/alu_ops_pkg.sv
design/lane_ctrl_if.sv
design/op_decode.sv
design/operand_bypass.sv
design/shift_unit.sv
design/alu_lane.sv
design/alu_cluster.sv
tb/alu_cluster_checker.sv
tb/alu_cluster_tb.sv

// File: tb/alu_cluster_checker.sv
/*
  Port-level assertions on the ALU cluster, bound into the DUT.
  The latency check assumes issue_valid is 0 throughout reset.
*/
`timescale 1ns/100ps

module alu_cluster_checker (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 issue_valid_0,
  input logic                 issue_valid_1,
  input alu_ops_pkg::alu_op_t op_0,
  input logic                 result_valid_0,
  input logic                 result_valid_1,
  input alu_types_pkg::word_t result_0,
  input alu_types_pkg::word_t result_1,
  input logic                 zero_0,
  input logic                 zero_1
);
  import alu_ops_pkg::*;

  int failures = 0; // failed assertions, read by the testbench at the end of the run.

  valid_in_reset: assert property (@(posedge clk) !arst_n |-> !result_valid_0 && !result_valid_1)
    else begin
      failures++;
      $error("result_valid is high while reset is asserted.");
    end

  latency_0: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid_0 == $past(issue_valid_0, 2))
    else begin
      failures++;
      $error("lane 0 result_valid does not follow issue_valid by 2 cycles.");
    end

  latency_1: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid_1 == $past(issue_valid_1, 2))
    else begin
      failures++;
      $error("lane 1 result_valid does not follow issue_valid by 2 cycles.");
    end

  // lane 0 has no shifter.
  no_shift_0: assert property (@(posedge clk) disable iff (!arst_n)
    issue_valid_0 |-> !(op_0 inside {op_shl64, op_shr64, op_sar64, op_shl32, op_shr32, op_sar32}))
    else begin
      failures++;
      $error("shift opcode issued to lane 0.");
    end

  zero_flag_0: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid_0 |-> (zero_0 == (result_0 == '0)))
    else begin
      failures++;
      $error("lane 0 zero flag disagrees with its result.");
    end

  zero_flag_1: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid_1 |-> (zero_1 == (result_1 == '0)))
    else begin
      failures++;
      $error("lane 1 zero flag disagrees with its result.");
    end

endmodule

// File: tb/alu_cluster_tb.sv
/*
  Directed tests for the two-lane ALU cluster against a cycle model of the lanes.
  Shift opcodes go to lane 1 only, since lane 0 has no shifter.
*/
`timescale 1ns/100ps

module alu_cluster_tb;
  import alu_types_pkg::*;
  import alu_ops_pkg::*;

  localparam int seed        = 30;
  localparam int n_arith     = 60;
  localparam int n_amounts   = 6;
  localparam int n_bypass    = 40;
  localparam int n_stream    = 50;
  localparam int drain       = 3;
  localparam int cycle_limit = 3 + (n_arith + drain) + (6 * n_amounts + drain) +
                               (3 + n_bypass + drain) + (n_stream + drain) + 20;

  typedef struct packed {
    logic     valid;
    alu_op_t  op;
    fwd_sel_t fa;
    fwd_sel_t fb;
    word_t    a;
    word_t    b;
  } issue_t;

  logic     clk;
  logic     arst_n;
  logic     issue_valid_0;
  alu_op_t  op_0;
  fwd_sel_t fwd_a_0;
  fwd_sel_t fwd_b_0;
  word_t    a_0;
  word_t    b_0;
  logic     result_valid_0;
  word_t    result_0;
  logic     zero_0;
  logic     issue_valid_1;
  alu_op_t  op_1;
  fwd_sel_t fwd_a_1;
  fwd_sel_t fwd_b_1;
  word_t    a_1;
  word_t    b_1;
  logic     result_valid_1;
  word_t    result_1;
  logic     zero_1;

  issue_t pending   [lane_count]; // set by the test for the next edge.
  issue_t presented [lane_count]; // on the DUT inputs now.
  issue_t stage     [lane_count]; // captured by the decode stage.
  word_t  m_res     [lane_count];
  logic   m_valid   [lane_count];
  int     issued    [lane_count];
  int     seen      [lane_count];
  int     errors;
  int     checks;
  int     tests;
  int     cycles;

  alu_cluster dut (.*);

  bind alu_cluster alu_cluster_checker u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .issue_valid_0  (issue_valid_0),
    .issue_valid_1  (issue_valid_1),
    .op_0           (op_0),
    .result_valid_0 (result_valid_0),
    .result_valid_1 (result_valid_1),
    .result_0       (result_0),
    .result_1       (result_1),
    .zero_0         (zero_0),
    .zero_1         (zero_1)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_limit);
    $display("Done: errors found");
    $finish;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic word_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic alu_op_t pick_op(input bit with_shift);
    int r;
    r = with_shift ? $urandom_range(12, 0) : $urandom_range(6, 0);
    if (r > 6) r = r + 1; // code 7 is not an opcode.
    return alu_op_t'(r[3:0]);
  endfunction

  function automatic word_t pick_source(input fwd_sel_t sel, input word_t operand);
    case (sel)
      2'd1:    return m_res[0];
      2'd2:    return m_res[1];
      default: return operand;
    endcase
  endfunction

  function automatic word_t model_op(input alu_op_t op, input word_t x, input word_t y);
    logic [31:0] lo;
    case (op)
      op_add64: return x + y;
      op_sub64: return x - y;
      op_and:   return x & y;
      op_or:    return x | y;
      op_xor:   return x ^ y;
      op_shl64: return x << y[5:0];
      op_shr64: return x >> y[5:0];
      op_sar64: return $signed(x) >>> y[5:0];
      op_add32: lo = x[31:0] + y[31:0];
      op_sub32: lo = x[31:0] - y[31:0];
      op_shl32: lo = x[31:0] << y[4:0];
      op_shr32: lo = x[31:0] >> y[4:0];
      op_sar32: lo = $signed(x[31:0]) >>> y[4:0];
      default:  lo = '0;
    endcase
    return {32'd0, lo}; // narrow forms are zero-extended.
  endfunction

  task automatic set_issue(input int n, input alu_op_t op, input fwd_sel_t fa,
                           input fwd_sel_t fb, input word_t a, input word_t b);
    pending[n].valid = 1'b1;
    pending[n].op    = op;
    pending[n].fa    = fa;
    pending[n].fb    = fb;
    pending[n].a     = a;
    pending[n].b     = b;
    issued[n]++;
  endtask

  // advances the model and the DUT by one clock edge and checks on the falling edge.
  task automatic step();
    word_t next_res [lane_count];
    int    n;
    @(posedge clk);
    for (n = 0; n < lane_count; n++) begin
      next_res[n] = m_res[n]; // the result register holds when idle.
      if (stage[n].valid) begin
        next_res[n] = model_op(stage[n].op, pick_source(stage[n].fa, stage[n].a),
                               pick_source(stage[n].fb, stage[n].b));
      end
    end
    for (n = 0; n < lane_count; n++) begin
      m_res[n]     = next_res[n];
      m_valid[n]   = stage[n].valid;
      stage[n]     = presented[n];
      presented[n] = pending[n];
      pending[n]   = '0;
    end
    issue_valid_0 <= presented[0].valid;
    op_0          <= presented[0].op;
    fwd_a_0       <= presented[0].fa;
    fwd_b_0       <= presented[0].fb;
    a_0           <= presented[0].a;
    b_0           <= presented[0].b;
    issue_valid_1 <= presented[1].valid;
    op_1          <= presented[1].op;
    fwd_a_1       <= presented[1].fa;
    fwd_b_1       <= presented[1].fb;
    a_1           <= presented[1].a;
    b_1           <= presented[1].b;
    @(negedge clk);
    check_bit("result_valid_0", result_valid_0, m_valid[0]);
    check_bit("result_valid_1", result_valid_1, m_valid[1]);
    if (result_valid_0) seen[0]++;
    if (result_valid_1) seen[1]++;
    if (m_valid[0]) begin
      check_word("result_0", result_0, m_res[0]);
      check_bit("zero_0", zero_0, m_res[0] == '0);
    end
    if (m_valid[1]) begin
      check_word("result_1", result_1, m_res[1]);
      check_bit("zero_1", zero_1, m_res[1] == '0);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    check_bit("result_valid_0", result_valid_0, 1'b0);
    check_bit("result_valid_1", result_valid_1, 1'b0);
    check_word("result_0", result_0, '0);
    check_word("result_1", result_1, '0);
    report_test("reset", e0);
  endtask

  task automatic test_arith();
    int    e0;
    int    i;
    int    n;
    word_t a;
    word_t b;
    e0 = errors;
    for (i = 0; i < n_arith; i++) begin
      for (n = 0; n < lane_count; n++) begin
        a = rand_word();
        b = ($urandom_range(5, 0) == 0) ? a : rand_word(); // sub and xor then give zero.
        set_issue(n, pick_op(1'b0), fwd_input, fwd_input, a, b);
      end
      step();
    end
    repeat (drain) step();
    report_test("arith", e0);
  endtask

  task automatic test_shift();
    alu_op_t shift_ops [6];
    int      e0;
    int      k;
    int      i;
    int      amt;
    int      max_amt;
    bit      narrow;
    word_t   a;
    word_t   b;
    e0 = errors;
    shift_ops = '{op_shl64, op_shr64, op_sar64, op_shl32, op_shr32, op_sar32};
    for (k = 0; k < 6; k++) begin
      narrow  = shift_ops[k] inside {op_shl32, op_shr32, op_sar32};
      max_amt = narrow ? 31 : 63;
      for (i = 0; i < n_amounts; i++) begin
        a     = rand_word();
        a[31] = i[0];  // alternate the sign of both forms.
        a[63] = ~i[0];
        b     = rand_word();
        if (i == 0) amt = 0;
        else if (i == 1) amt = max_amt;
        else amt = $urandom_range(max_amt, 1);
        if (narrow) b[4:0] = amt[4:0];
        else b[5:0] = amt[5:0];
        set_issue(1, shift_ops[k], fwd_input, fwd_input, a, b);
        step();
      end
    end
    repeat (drain) step();
    report_test("shift", e0);
  endtask

  task automatic test_bypass();
    int e0;
    int i;
    int n;
    e0 = errors;
    set_issue(0, op_add64, fwd_input, fwd_input, rand_word(), rand_word());
    set_issue(1, op_or, fwd_input, fwd_input, rand_word(), rand_word());
    step();
    set_issue(0, op_sub64, fwd_lane0, fwd_input, '0, rand_word());
    set_issue(1, op_xor, fwd_lane0, fwd_lane1, '0, '0);
    step();
    set_issue(0, op_and, fwd_lane1, fwd_lane0, '0, '0);
    set_issue(1, op_shl64, fwd_lane1, fwd_input, '0, 64'd4);
    step();
    for (i = 0; i < n_bypass; i++) begin
      for (n = 0; n < lane_count; n++) begin
        set_issue(n, pick_op(n == 1), fwd_sel_t'($urandom_range(3, 0)),
                  fwd_sel_t'($urandom_range(3, 0)), rand_word(), rand_word());
      end
      step();
    end
    repeat (drain) step();
    report_test("bypass", e0);
  endtask

  task automatic test_stream();
    int e0;
    int i;
    int n;
    e0 = errors;
    for (i = 0; i < n_stream; i++) begin
      for (n = 0; n < lane_count; n++) begin
        set_issue(n, pick_op(n == 1), fwd_input, fwd_input, rand_word(), rand_word());
      end
      step();
    end
    repeat (drain) step();
    for (n = 0; n < lane_count; n++) begin
      if (seen[n] != issued[n]) begin
        errors++;
        $display("lane %0d delivered %0d results for %0d issues", n, seen[n], issued[n]);
      end
    end
    report_test("stream", e0);
  endtask

  initial begin
    int seed_ret;
    int n;
    seed_ret      = $urandom(seed);
    errors        = 0;
    checks        = 0;
    tests         = 0;
    arst_n        = 1'b0;
    issue_valid_0 = 1'b0;
    op_0          = op_add64;
    fwd_a_0       = fwd_input;
    fwd_b_0       = fwd_input;
    a_0           = '0;
    b_0           = '0;
    issue_valid_1 = 1'b0;
    op_1          = op_add64;
    fwd_a_1       = fwd_input;
    fwd_b_1       = fwd_input;
    a_1           = '0;
    b_1           = '0;
    for (n = 0; n < lane_count; n++) begin
      pending[n]   = '0;
      presented[n] = '0;
      stage[n]     = '0;
      m_res[n]     = '0;
      m_valid[n]   = 1'b0;
      issued[n]    = 0;
      seen[n]      = 0;
    end
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    test_reset();
    test_arith();
    test_shift();
    test_bypass();
    test_stream();
    if (dut.u_checker.failures != 0) begin
      errors = errors + dut.u_checker.failures;
      $display("the checker flagged %0d assertion failures", dut.u_checker.failures);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
